//--- hdl/fe_settings.svh
`ifndef FE_SETTINGS_SVH
`define FE_SETTINGS_SVH

// width of pc and instruction memory addresses
`define FE_ADDR_W 32

// first fetch address after reset
`define FE_RESET_VEC 32'h0000_0200

// misprediction counter width, saturates at all ones
`define FE_CNT_W 16

`endif

//--- hdl/fe_pkg.sv
`default_nettype none

`include "fe_settings.svh"

package fe_pkg;

    // pc and address values across the fetch unit
    typedef logic [`FE_ADDR_W-1:0] addr_t;

    typedef enum logic {
        B_NT = 1'b0,
        B_T  = 1'b1
    } branch_t;

    // next pc source
    typedef enum logic [1:0] {
        PC_SEL_PC   = 2'd0,  // hold current pc
        PC_SEL_INC4 = 2'd1,
        PC_SEL_ALU  = 2'd2,
        PC_SEL_BP   = 2'd3
    } pc_sel_t;

    // controls for the pc register and the decode stage
    typedef struct packed {
        pc_sel_t pc_sel;
        logic    pc_we;
        logic    bubble_dec;
        // take pc+4 from the checkpoint instead of the current pc
        logic    use_cp;
    } fe_ctrl_t;

    typedef struct packed {
        logic enter;
        logic resolve;
        logic wrong;
    } spec_t;

    typedef struct packed {
        logic  valid;
        addr_t addr;
    } imem_req_t;

    typedef struct packed {
        logic valid;
    } imem_rsp_t;

    // addr 0 is the prediction enable, addr 1 the misprediction counter
    typedef struct packed {
        logic                 we;
        logic                 addr;
        logic [`FE_CNT_W-1:0] data;
    } cfg_wr_t;

endpackage

`default_nettype wire

//--- hdl/fe_cfg_regs.sv
`default_nettype none

`include "fe_settings.svh"

module fe_cfg_regs
    import fe_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  cfg_wr_t              cfg_wr,
    input  logic                 rd_addr,
    input  logic                 mispredict,
    output logic                 bp_en,
    output logic [`FE_CNT_W-1:0] rd_data
);

    logic [`FE_CNT_W-1:0] mp_cnt;

    // prediction is off until software turns it on
    always_ff @(posedge clk) begin
        if (rst) begin
            bp_en <= 1'b0;
        end else if (cfg_wr.we && !cfg_wr.addr) begin
            bp_en <= cfg_wr.data[0];
        end
    end

    // any write to addr 1 clears the count, whatever the data
    always_ff @(posedge clk) begin
        if (rst) begin
            mp_cnt <= '0;
        end else if (cfg_wr.we && cfg_wr.addr) begin
            mp_cnt <= '0;
        end else if (mispredict && (mp_cnt != '1)) begin
            mp_cnt <= mp_cnt + 1'b1;
        end
    end

    assign rd_data = rd_addr ? mp_cnt : {{(`FE_CNT_W-1){1'b0}}, bp_en};

endmodule

`default_nettype wire

//--- hdl/fe_stall_ctrl.sv
`default_nettype none

module fe_stall_ctrl
    import fe_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     imem_req_ready,
    input  logic     imem_rsp_valid,
    input  addr_t    pc_dec,
    input  addr_t    pc_exe,
    input  logic     branch_inst_dec,
    input  logic     jump_inst_dec,
    input  logic     branch_inst_exe,
    input  logic     jump_inst_exe,
    input  branch_t  bp_pred,
    input  branch_t  branch_resolution,
    input  logic     dc_stalled,
    input  logic     load_hazard_stall,
    input  logic     bp_en,
    input  spec_t    spec,
    input  fe_ctrl_t decoded_fe_ctrl,
    output fe_ctrl_t fe_ctrl,
    output logic     imem_req_valid,
    output logic     imem_rsp_ready,
    output logic     move_past_dec_stall
);

    typedef enum logic [2:0] {
        RST,
        STEADY,
        STALL_FLOW,
        STALL_FE_IC,
        STALL_BE_DC
    } state_t;

    typedef enum logic [1:0] {
        STALL_NONE,
        STALL_BRANCH,
        STALL_JUMP
    } stall_kind_t;

    typedef struct packed {
        stall_kind_t kind;
        addr_t       pc;
    } stall_entry_t;

    typedef struct packed {
        logic flow;
        logic icache;
        logic dcache;
    } stall_src_t;

    // everything the fetch side drives in one cycle
    typedef struct packed {
        fe_ctrl_t ctrl;
        logic     req_valid;
        logic     rsp_ready;
    } fe_out_t;

    function automatic fe_out_t mk_out(pc_sel_t sel, logic we, logic bubble,
                                       logic req, logic rsp);
        return '{ctrl: '{pc_sel: sel, pc_we: we, bubble_dec: bubble, use_cp: 1'b0},
                 req_valid: req, rsp_ready: rsp};
    endfunction

    state_t       state, nx_state;
    stall_entry_t stalled;
    stall_src_t   act;
    logic         res_flow;
    logic         branch_taken, flow_changed;
    logic         save_entry, clear_entry;
    fe_ctrl_t     dec_ctrl_q;
    fe_out_t      ctl_out, stop_out, enter_out, redirect_out;

    assign branch_taken = branch_inst_exe && (branch_resolution == B_T);
    assign flow_changed = (stalled.kind == STALL_JUMP) ? jump_inst_exe : branch_taken;

    // with prediction on, branches go through the speculation tracker
    assign act.flow   = jump_inst_dec || (branch_inst_dec && !bp_en);
    assign act.icache = !imem_req_ready;
    assign act.dcache = dc_stalled;

    // the stalled instruction reached execute and can be resolved there
    assign res_flow = (stalled.pc == pc_exe) && (pc_exe != '0)
                      && !load_hazard_stall && !dc_stalled;

    assign stop_out  = mk_out(PC_SEL_PC, 1'b0, 1'b0, 1'b0, 1'b0);
    assign enter_out = mk_out((bp_pred == B_T) ? PC_SEL_BP : PC_SEL_INC4,
                              1'b1, 1'b0, 1'b1, 1'b1);

    // restart after the mispredicted branch, flushing decode
    always_comb begin
        redirect_out = mk_out(branch_taken ? PC_SEL_ALU : PC_SEL_INC4,
                              1'b1, 1'b1, 1'b1, 1'b1);
        redirect_out.ctrl.use_cp = 1'b1;
    end

    always_comb begin
        nx_state = state;
        save_entry = 1'b0;
        clear_entry = 1'b0;
        case (state)
            RST: begin
                // first request goes out as soon as imem takes it
                if (imem_req_ready) nx_state = STALL_FE_IC;
            end
            STEADY: begin
                clear_entry = 1'b1;
                if (act.dcache) begin
                    nx_state = STALL_BE_DC;
                end else if (act.flow) begin
                    save_entry = 1'b1;
                    nx_state = STALL_FLOW;
                end else if (act.icache) begin
                    nx_state = STALL_FE_IC;
                end
                if (spec.wrong) nx_state = STEADY;
            end
            STALL_FLOW: begin
                if (spec.wrong) begin
                    nx_state = STEADY;
                end else if (res_flow) begin
                    nx_state = act.icache ? STALL_FE_IC : STEADY;
                end
            end
            STALL_FE_IC: begin
                if (spec.wrong) begin
                    nx_state = STEADY;
                end else if (imem_rsp_valid) begin
                    if (act.dcache) begin
                        nx_state = STALL_BE_DC;
                    end else if (act.flow) begin
                        save_entry = 1'b1;
                        nx_state = STALL_FLOW;
                    end else begin
                        nx_state = STEADY;
                    end
                end
            end
            STALL_BE_DC: begin
                if (!act.dcache) begin
                    if (act.flow) begin
                        save_entry = 1'b1;
                        nx_state = STALL_FLOW;
                    end else if (act.icache) begin
                        nx_state = STALL_FE_IC;
                    end else begin
                        nx_state = STEADY;
                    end
                end
            end
            default: nx_state = RST;
        endcase
    end

    always_comb begin
        ctl_out = mk_out(dec_ctrl_q.pc_sel, dec_ctrl_q.pc_we, 1'b0, 1'b0, 1'b0);
        move_past_dec_stall = 1'b0;
        case (state)
            RST: ctl_out = mk_out(PC_SEL_PC, 1'b0, 1'b1, 1'b1, 1'b1);
            STEADY: begin
                ctl_out = mk_out(decoded_fe_ctrl.pc_sel, decoded_fe_ctrl.pc_we,
                                 1'b0, 1'b1, 1'b1);
                if (act.dcache || act.flow) begin
                    ctl_out = stop_out;
                end else if (act.icache) begin
                    ctl_out = mk_out(PC_SEL_PC, 1'b0, 1'b1, 1'b0, 1'b1);
                end else if (spec.enter) begin
                    ctl_out = enter_out;
                end
                if (spec.wrong) ctl_out = redirect_out;
            end
            STALL_FLOW: begin
                ctl_out.ctrl.pc_we = 1'b0;
                ctl_out.ctrl.bubble_dec = 1'b1;
                if (spec.wrong) begin
                    ctl_out = redirect_out;
                end else if (res_flow) begin
                    ctl_out = mk_out(flow_changed ? PC_SEL_ALU : PC_SEL_INC4,
                                     1'b1, 1'b1, 1'b1, 1'b1);
                    move_past_dec_stall = 1'b1;
                end
            end
            STALL_FE_IC: begin
                // wait for the instruction, keep decode empty
                ctl_out = mk_out(PC_SEL_PC, 1'b0, 1'b1, 1'b0, 1'b1);
                if (imem_rsp_valid) begin
                    if (act.dcache || act.flow) begin
                        ctl_out = stop_out;
                    end else if (spec.enter) begin
                        ctl_out = enter_out;
                    end else begin
                        ctl_out = mk_out(dec_ctrl_q.pc_sel, 1'b1, 1'b0, 1'b1, 1'b1);
                    end
                end
                if (spec.wrong) ctl_out = redirect_out;
            end
            STALL_BE_DC: begin
                ctl_out.ctrl.pc_we = 1'b0;
                if (!act.dcache) begin
                    if (act.icache) begin
                        ctl_out = mk_out(PC_SEL_PC, 1'b0, 1'b1, 1'b0, 1'b1);
                    end else if (act.flow) begin
                        ctl_out = stop_out;
                    end else if (spec.wrong) begin
                        ctl_out = redirect_out;
                    end else if (spec.enter) begin
                        ctl_out = enter_out;
                    end else begin
                        ctl_out = mk_out(dec_ctrl_q.pc_sel, 1'b1, 1'b0, 1'b1, 1'b1);
                    end
                end
            end
            default: ;
        endcase
    end

    assign fe_ctrl = ctl_out.ctrl;
    assign imem_req_valid = ctl_out.req_valid;
    assign imem_rsp_ready = ctl_out.rsp_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= RST;
            dec_ctrl_q <= '{pc_sel: PC_SEL_PC, pc_we: 1'b0, bubble_dec: 1'b1, use_cp: 1'b0};
        end else begin
            state <= nx_state;
            dec_ctrl_q <= decoded_fe_ctrl;
        end
    end

    // save wins when both fire in the same cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            stalled <= '{kind: STALL_NONE, pc: '0};
        end else if (save_entry) begin
            stalled <= '{kind: branch_inst_dec ? STALL_BRANCH : STALL_JUMP, pc: pc_dec};
        end else if (clear_entry) begin
            stalled <= '{kind: STALL_NONE, pc: '0};
        end
    end

endmodule

`default_nettype wire

//--- hdl/fe_spec_tracker.sv
`default_nettype none

module fe_spec_tracker
    import fe_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    bp_en,
    input  addr_t   pc_dec,
    input  addr_t   pc_exe,
    input  logic    branch_inst_dec,
    input  branch_t bp_pred,
    input  branch_t branch_resolution,
    input  logic    dc_stalled,
    input  logic    load_hazard_stall,
    output spec_t   spec,
    output logic    bp_hit,
    output addr_t   pc_cp
);

    typedef enum logic {
        NS_E,   // non-speculative
        SPEC_E
    } exec_state_t;

    typedef struct packed {
        addr_t   pc;
        branch_t b_tnt;
    } spec_entry_t;

    exec_state_t state, nx_state;
    spec_entry_t entry;
    logic        active, dec_ok;

    assign active = bp_en && (state == SPEC_E);
    // nothing moves through decode or execute while either is held
    assign dec_ok = bp_en && branch_inst_dec && !dc_stalled && !load_hazard_stall;

    assign spec.resolve = active && (entry.pc == pc_exe) && (pc_exe != '0)
                          && !dc_stalled && !load_hazard_stall;
    assign bp_hit = spec.resolve && (entry.b_tnt == branch_resolution);
    assign spec.wrong = spec.resolve && !bp_hit;

    // one branch in flight, the slot frees on a correct resolve
    assign spec.enter = dec_ok && (!active || bp_hit);

    assign pc_cp = active ? entry.pc : '0;

    always_comb begin
        nx_state = state;
        case (state)
            NS_E: begin
                if (spec.enter) nx_state = SPEC_E;
            end
            SPEC_E: begin
                // a hit with another branch in decode stays speculative
                if (!bp_en || (spec.resolve && !spec.enter)) nx_state = NS_E;
            end
            default: nx_state = NS_E;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) state <= NS_E;
        else state <= nx_state;
    end

    always_ff @(posedge clk) begin
        if (spec.enter) entry <= '{pc: pc_dec, b_tnt: bp_pred};
    end

endmodule

`default_nettype wire

//--- hdl/fe_pc_gen.sv
`default_nettype none

`include "fe_settings.svh"

module fe_pc_gen
    import fe_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  fe_ctrl_t fe_ctrl,
    input  addr_t    alu_target,
    input  addr_t    bp_target,
    input  addr_t    pc_cp,
    output addr_t    pc
);

    addr_t inc_base;
    addr_t pc_nx;

    // recovery continues after the mispredicted branch
    assign inc_base = fe_ctrl.use_cp ? pc_cp : pc;

    always_comb begin
        case (fe_ctrl.pc_sel)
            PC_SEL_PC:   pc_nx = pc;
            PC_SEL_INC4: pc_nx = inc_base + addr_t'(4);
            PC_SEL_ALU:  pc_nx = alu_target;
            PC_SEL_BP:   pc_nx = bp_target;
            default:     pc_nx = pc;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= `FE_RESET_VEC;
        end else if (fe_ctrl.pc_we) begin
            pc <= pc_nx;
        end
    end

endmodule

`default_nettype wire

//--- hdl/fe_top.sv
`default_nettype none

`include "fe_settings.svh"

module fe_top
    import fe_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    // decode stage
    input  addr_t                pc_dec,
    input  logic                 branch_inst_dec,
    input  logic                 jump_inst_dec,
    input  branch_t              bp_pred,
    input  addr_t                bp_target,
    input  fe_ctrl_t             decoded_fe_ctrl,
    // execute stage
    input  addr_t                pc_exe,
    input  logic                 branch_inst_exe,
    input  logic                 jump_inst_exe,
    input  branch_t              branch_resolution,
    input  addr_t                alu_target,
    // back end
    input  logic                 dc_stalled,
    input  logic                 load_hazard_stall,
    // instruction memory
    output imem_req_t            imem_req,
    input  logic                 imem_req_ready,
    input  imem_rsp_t            imem_rsp,
    output logic                 imem_rsp_ready,
    // configuration
    input  cfg_wr_t              cfg_wr,
    input  logic                 rd_addr,
    output logic [`FE_CNT_W-1:0] rd_data,
    // status
    output fe_ctrl_t             fe_ctrl,
    output logic                 bp_hit,
    output addr_t                pc_cp,
    output logic                 move_past_dec_stall
);

    logic  bp_en;
    logic  req_valid;
    spec_t spec;
    addr_t pc;

    fe_cfg_regs u_cfg_regs (
        .clk        (clk),
        .rst        (rst),
        .cfg_wr     (cfg_wr),
        .rd_addr    (rd_addr),
        .mispredict (spec.wrong),
        .bp_en      (bp_en),
        .rd_data    (rd_data)
    );

    fe_stall_ctrl u_stall_ctrl (
        .clk                 (clk),
        .rst                 (rst),
        .imem_req_ready      (imem_req_ready),
        .imem_rsp_valid      (imem_rsp.valid),
        .pc_dec              (pc_dec),
        .pc_exe              (pc_exe),
        .branch_inst_dec     (branch_inst_dec),
        .jump_inst_dec       (jump_inst_dec),
        .branch_inst_exe     (branch_inst_exe),
        .jump_inst_exe       (jump_inst_exe),
        .bp_pred             (bp_pred),
        .branch_resolution   (branch_resolution),
        .dc_stalled          (dc_stalled),
        .load_hazard_stall   (load_hazard_stall),
        .bp_en               (bp_en),
        .spec                (spec),
        .decoded_fe_ctrl     (decoded_fe_ctrl),
        .fe_ctrl             (fe_ctrl),
        .imem_req_valid      (req_valid),
        .imem_rsp_ready      (imem_rsp_ready),
        .move_past_dec_stall (move_past_dec_stall)
    );

    fe_spec_tracker u_spec_tracker (
        .clk               (clk),
        .rst               (rst),
        .bp_en             (bp_en),
        .pc_dec            (pc_dec),
        .pc_exe            (pc_exe),
        .branch_inst_dec   (branch_inst_dec),
        .bp_pred           (bp_pred),
        .branch_resolution (branch_resolution),
        .dc_stalled        (dc_stalled),
        .load_hazard_stall (load_hazard_stall),
        .spec              (spec),
        .bp_hit            (bp_hit),
        .pc_cp             (pc_cp)
    );

    fe_pc_gen u_pc_gen (
        .clk        (clk),
        .rst        (rst),
        .fe_ctrl    (fe_ctrl),
        .alu_target (alu_target),
        .bp_target  (bp_target),
        .pc_cp      (pc_cp),
        .pc         (pc)
    );

    // fetch always requests the current pc
    assign imem_req = '{valid: req_valid, addr: pc};

endmodule

`default_nettype wire

//--- dv/fe_assertions.sv
`default_nettype none

`include "fe_settings.svh"

module fe_assertions
    import fe_pkg::*;
(
    input logic                 clk,
    input logic                 rst,
    input cfg_wr_t              cfg_wr,
    input logic                 rd_addr,
    input logic [`FE_CNT_W-1:0] rd_data,
    input addr_t                pc_dec,
    input addr_t                pc_exe,
    input logic                 branch_inst_dec,
    input logic                 jump_inst_dec,
    input logic                 branch_inst_exe,
    input logic                 jump_inst_exe,
    input branch_t              bp_pred,
    input branch_t              branch_resolution,
    input addr_t                alu_target,
    input logic                 dc_stalled,
    input logic                 load_hazard_stall,
    input imem_req_t            imem_req,
    input logic                 imem_req_ready,
    input imem_rsp_t            imem_rsp,
    input logic                 imem_rsp_ready,
    input fe_ctrl_t             fe_ctrl,
    input logic                 bp_hit,
    input addr_t                pc_cp,
    input logic                 move_past_dec_stall
);
    timeunit 1ns;
    timeprecision 1ps;

    int unsigned fails = 0;

    logic                 booted;
    logic                 bp_en_m;
    logic [`FE_CNT_W-1:0] mp_m;
    // flow stall model
    logic                 fl_pend, fl_jump, fl_start, fl_res, fl_taken;
    addr_t                fl_pc, fl_exp;
    // speculation model
    logic                 sp_act, sp_pred, sp_enter, sp_res, sp_hit, sp_taken;
    addr_t                sp_pc, sp_exp;
    logic                 quiet;

    assign quiet = !dc_stalled && !load_hazard_stall;

    assign fl_start = booted && quiet && imem_req_ready && imem_rsp.valid && !fl_pend
                      && (jump_inst_dec || (branch_inst_dec && !bp_en_m));
    assign fl_res = fl_pend && (pc_exe == fl_pc) && (pc_exe != '0) && quiet;
    assign fl_taken = fl_jump ? jump_inst_exe
                              : (branch_inst_exe && (branch_resolution == B_T));
    assign fl_exp = fl_taken ? alu_target : fl_pc + 32'd4;

    assign sp_res = bp_en_m && sp_act && (pc_exe == sp_pc) && (pc_exe != '0) && quiet;
    assign sp_hit = sp_res && (sp_pred == branch_resolution);
    assign sp_enter = bp_en_m && branch_inst_dec && quiet && (!sp_act || sp_hit);
    assign sp_taken = branch_inst_exe && (branch_resolution == B_T);
    assign sp_exp = sp_taken ? alu_target : sp_pc + 32'd4;

    always_ff @(posedge clk) begin
        if (rst) begin
            booted <= 1'b0;
            bp_en_m <= 1'b0;
            mp_m <= '0;
            fl_pend <= 1'b0;
            sp_act <= 1'b0;
        end else begin
            if (imem_rsp.valid && imem_rsp_ready) booted <= 1'b1;
            if (cfg_wr.we && !cfg_wr.addr) bp_en_m <= cfg_wr.data[0];
            if (cfg_wr.we && cfg_wr.addr) begin
                mp_m <= '0;
            end else if (sp_res && !sp_hit && (mp_m != '1)) begin
                mp_m <= mp_m + 1'b1;
            end
            if (fl_start) begin
                fl_pend <= 1'b1;
                fl_pc <= pc_dec;
                fl_jump <= jump_inst_dec;
            end else if (fl_res) begin
                fl_pend <= 1'b0;
            end
            if (sp_enter) begin
                sp_act <= 1'b1;
                sp_pc <= pc_dec;
                sp_pred <= bp_pred;
            end else if (sp_res) begin
                sp_act <= 1'b0;
            end
        end
    end

    boot_state: assert property (@(posedge clk) $past(rst) |->
        imem_req.addr == `FE_RESET_VEC && fe_ctrl.bubble_dec && imem_req.valid)
        else begin
            $error("FAILED t=%0t boot addr exp %h got %h, bubble_dec %b, valid %b",
                   $time, `FE_RESET_VEC, imem_req.addr, fe_ctrl.bubble_dec, imem_req.valid);
            fails++;
        end

    boot_hold: assert property (@(posedge clk) disable iff (rst)
        !booted && !(imem_rsp.valid && imem_rsp_ready) |-> !fe_ctrl.pc_we)
        else begin
            $error("FAILED t=%0t pc_we exp 0 got %b before first response",
                   $time, fe_ctrl.pc_we);
            fails++;
        end

    ic_backpressure: assert property (@(posedge clk) disable iff (rst)
        booted && !imem_req_ready && !imem_rsp.valid && !dc_stalled
        && !branch_inst_dec && !jump_inst_dec && !fl_pend
        |-> fe_ctrl.bubble_dec ##1 $stable(imem_req.addr))
        else begin
            $error("FAILED t=%0t bubble_dec %b or pc moved to %h under back-pressure",
                   $time, fe_ctrl.bubble_dec, imem_req.addr);
            fails++;
        end

    dc_stall: assert property (@(posedge clk) disable iff (rst)
        booted && dc_stalled && imem_req_ready && imem_rsp.valid
        |-> !imem_req.valid && !imem_rsp_ready && !fe_ctrl.pc_we)
        else begin
            $error("FAILED t=%0t dc stall exp 0/0/0 got valid %b rsp_ready %b pc_we %b",
                   $time, imem_req.valid, imem_rsp_ready, fe_ctrl.pc_we);
            fails++;
        end

    dc_resume: assert property (@(posedge clk) disable iff (rst)
        booted && $fell(dc_stalled) && imem_req_ready && imem_rsp.valid
        |-> imem_req.valid && fe_ctrl.pc_we ##1 imem_req.addr != $past(imem_req.addr))
        else begin
            $error("FAILED t=%0t fetch did not resume after dc stall, pc %h",
                   $time, imem_req.addr);
            fails++;
        end

    flow_hold: assert property (@(posedge clk) disable iff (rst)
        fl_start || (fl_pend && !fl_res) |-> !fe_ctrl.pc_we)
        else begin
            $error("FAILED t=%0t pc_we exp 0 got %b during flow stall", $time, fe_ctrl.pc_we);
            fails++;
        end

    flow_target: assert property (@(posedge clk) disable iff (rst)
        fl_res |-> fe_ctrl.pc_we ##1 imem_req.addr == $past(fl_exp))
        else begin
            $error("FAILED t=%0t pc after flow stall exp %h got %h",
                   $time, $past(fl_exp), imem_req.addr);
            fails++;
        end

    flow_release: assert property (@(posedge clk) disable iff (rst)
        fl_res |-> move_past_dec_stall)
        else begin
            $error("FAILED t=%0t move_past_dec_stall exp 1 got %b",
                   $time, move_past_dec_stall);
            fails++;
        end

    spec_hit: assert property (@(posedge clk) disable iff (rst)
        sp_hit |-> bp_hit && !fe_ctrl.use_cp)
        else begin
            $error("FAILED t=%0t correct prediction gave bp_hit %b use_cp %b",
                   $time, bp_hit, fe_ctrl.use_cp);
            fails++;
        end

    spec_redirect: assert property (@(posedge clk) disable iff (rst)
        sp_res && !sp_hit |-> fe_ctrl.use_cp && fe_ctrl.pc_we
        ##1 imem_req.addr == $past(sp_exp))
        else begin
            $error("FAILED t=%0t pc after misprediction exp %h got %h",
                   $time, $past(sp_exp), imem_req.addr);
            fails++;
        end

    // checkpoint follows the branch held by the tracker
    spec_cp: assert property (@(posedge clk) disable iff (rst)
        bp_en_m && sp_act |-> pc_cp == sp_pc)
        else begin
            $error("FAILED t=%0t pc_cp exp %h got %h", $time, sp_pc, pc_cp);
            fails++;
        end

    spec_off: assert property (@(posedge clk) disable iff (rst)
        !bp_en_m |-> !bp_hit && pc_cp == '0)
        else begin
            $error("FAILED t=%0t bp_hit exp 0 got %b, pc_cp exp 0 got %h",
                   $time, bp_hit, pc_cp);
            fails++;
        end

    mp_count: assert property (@(posedge clk) disable iff (rst)
        rd_addr |-> rd_data == mp_m)
        else begin
            $error("FAILED t=%0t rd_data exp %0d got %0d", $time, mp_m, rd_data);
            fails++;
        end

    cfg_read: assert property (@(posedge clk) disable iff (rst)
        !rd_addr |-> rd_data[0] == bp_en_m && rd_data[`FE_CNT_W-1:1] == '0)
        else begin
            $error("FAILED t=%0t rd_data exp %0d got %0d", $time, bp_en_m, rd_data);
            fails++;
        end

endmodule

bind fe_top fe_assertions u_fe_assert (.*);

`default_nettype wire

//--- dv/fe_clk_gen.sv
`default_nettype none

module fe_clk_gen (
    output logic clk,
    output logic rst
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // reset held for five rising edges, released just after the last one
    initial begin
        rst = 1'b1;
        repeat (5) @(posedge clk);
        #10 rst = 1'b0;
    end

endmodule

`default_nettype wire

//--- dv/fe_tb.sv
`default_nettype none

`include "fe_settings.svh"

module fe_tb
    import fe_pkg::*;
;
    timeunit 1ns;
    timeprecision 1ps;

    // cycle budgets of boot, icache, dcache, flow and speculation tests
    localparam int BUDGET = 40 + 80 + 80 + 120 + 120;
    localparam int MARGIN = 100;

    logic                 clk, rst;
    addr_t                pc_dec, pc_exe, bp_target, alu_target, pc_cp;
    logic                 branch_inst_dec, jump_inst_dec, branch_inst_exe, jump_inst_exe;
    branch_t              bp_pred, branch_resolution;
    fe_ctrl_t             decoded_fe_ctrl, fe_ctrl;
    logic                 dc_stalled, load_hazard_stall;
    imem_req_t            imem_req;
    logic                 imem_req_ready, imem_rsp_ready;
    imem_rsp_t            imem_rsp;
    cfg_wr_t              cfg_wr;
    logic                 rd_addr, bp_hit, move_past_dec_stall;
    logic [`FE_CNT_W-1:0] rd_data;

    logic [15:0] lfsr = 16'd46424;
    int          errs = 0;
    int          last_err = 0;
    int          n_tests = 0;

    fe_clk_gen u_clk_gen (.clk(clk), .rst(rst));

    fe_top DUT (.*);

    // one shift per bit taken, taps 16 14 13 11
    function automatic int draw(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
            v = (v << 1) | lfsr[0];
        end
        return v;
    endfunction

    // inputs move 10 ns after the rising edge
    task automatic step(input int n);
        repeat (n) begin
            @(posedge clk);
            #10;
        end
    endtask

    task automatic report(input string name);
        int now_err;
        now_err = errs + DUT.u_fe_assert.fails;
        n_tests++;
        $display("test %-8s done, %0d errors", name, now_err - last_err);
        last_err = now_err;
    endtask

    initial begin
        #((BUDGET + MARGIN) * 100);
        $display("watchdog expired after %0d cycles, run did not finish", BUDGET + MARGIN);
        $display("=== FAIL ===");
        $finish;
    end

    initial begin
        int    v;
        int    wrongs;
        addr_t saved;

        pc_dec = '0;
        pc_exe = '0;
        bp_target = '0;
        alu_target = '0;
        branch_inst_dec = 1'b0;
        jump_inst_dec = 1'b0;
        branch_inst_exe = 1'b0;
        jump_inst_exe = 1'b0;
        bp_pred = B_NT;
        branch_resolution = B_NT;
        decoded_fe_ctrl = '{pc_sel: PC_SEL_INC4, pc_we: 1'b1, bubble_dec: 1'b0, use_cp: 1'b0};
        dc_stalled = 1'b0;
        load_hazard_stall = 1'b0;
        imem_req_ready = 1'b0;
        imem_rsp = '{valid: 1'b0};
        cfg_wr = '{we: 1'b0, addr: 1'b0, data: '0};
        rd_addr = 1'b1;

        @(negedge rst);
        step(2);
        imem_req_ready = 1'b1;
        v = draw(4);
        step(v + 1);
        imem_rsp.valid = 1'b1;
        @(negedge clk);
        while (!fe_ctrl.pc_we) @(negedge clk);
        step(2);
        report("boot");

        for (int i = 0; i < 40; i++) begin
            v = draw(2);
            imem_req_ready = (v != 0);
            imem_rsp.valid = (v != 0);
            step(1);
        end
        imem_req_ready = 1'b1;
        imem_rsp.valid = 1'b1;
        step(2);
        report("icache");

        for (int i = 0; i < 3; i++) begin
            v = draw(4);
            dc_stalled = 1'b1;
            step(v + 1);
            dc_stalled = 1'b0;
            step(3);
        end
        report("dcache");

        // two branches then a jump, prediction off
        for (int i = 0; i < 3; i++) begin
            saved = imem_req.addr;
            pc_dec = saved;
            branch_inst_dec = (i != 2);
            jump_inst_dec = (i == 2);
            step(1);
            branch_inst_dec = 1'b0;
            jump_inst_dec = 1'b0;
            v = draw(4);
            step(v + 1);
            pc_exe = saved;
            branch_inst_exe = (i != 2);
            jump_inst_exe = (i == 2);
            branch_resolution = branch_t'(i == 1);
            v = draw(12);
            alu_target = 32'h0000_8000 + (v << 2);
            step(1);
            pc_exe = '0;
            branch_inst_exe = 1'b0;
            jump_inst_exe = 1'b0;
            step(2);
        end
        report("flow");

        cfg_wr = '{we: 1'b1, addr: 1'b0, data: 16'd1};
        step(1);
        cfg_wr.we = 1'b0;
        // read back the enable bit for one cycle
        rd_addr = 1'b0;
        step(1);
        rd_addr = 1'b1;
        wrongs = 0;
        for (int i = 0; i < 8; i++) begin
            saved = 32'h0000_1000 + i * 16;
            pc_dec = saved;
            v = draw(1);
            bp_pred = branch_t'(v[0]);
            v = draw(12);
            bp_target = 32'h0000_4000 + (v << 2);
            branch_inst_dec = 1'b1;
            step(1);
            branch_inst_dec = 1'b0;
            step(2);
            pc_exe = saved;
            branch_inst_exe = 1'b1;
            v = draw(1);
            branch_resolution = branch_t'(v[0]);
            if (branch_resolution != bp_pred) wrongs++;
            v = draw(12);
            alu_target = 32'h0000_8000 + (v << 2);
            step(1);
            pc_exe = '0;
            branch_inst_exe = 1'b0;
            step(1);
        end
        @(negedge clk);
        if (rd_data != wrongs) begin
            $display("FAILED t=%0t rd_data exp %0d got %0d", $time, wrongs, rd_data);
            errs++;
        end
        step(1);
        cfg_wr = '{we: 1'b1, addr: 1'b1, data: '0};
        step(1);
        cfg_wr.we = 1'b0;
        @(negedge clk);
        if (rd_data != 0) begin
            $display("FAILED t=%0t rd_data exp 0 got %0d", $time, rd_data);
            errs++;
        end
        step(1);
        report("spec");

        $display("tests run %0d, errors %0d", n_tests, last_err);
        if (last_err == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- flist.f
+incdir+hdl
hdl/fe_pkg.sv
hdl/fe_cfg_regs.sv
hdl/fe_stall_ctrl.sv
hdl/fe_spec_tracker.sv
hdl/fe_pc_gen.sv
hdl/fe_top.sv
dv/fe_assertions.sv
dv/fe_clk_gen.sv
dv/fe_tb.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module fe_tb -f flist.f -o fe_sim
	./obj_dir/fe_sim | tee /dev/stderr | grep -q -F "=== PASS ==="

clean:
	rm -rf obj_dir
